//--- hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // ----------------------------------------
  // native memory bus widths
  // ----------------------------------------
  localparam int WORD_W = 32;  // data word
  localparam int ADDR_W = 32;  // byte address
  localparam int STRB_W = WORD_W / 8;  // one enable per byte lane

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;  // all zero on a read

  // where a decoded access is sent
  typedef enum logic [1:0] {
    TGT_SRAM = 2'd0,
    TGT_LED  = 2'd1,
    TGT_NONE = 2'd2  // empty region, zero data
  } target_e;

  typedef enum logic [1:0] {
    DEC_IDLE = 2'd0,  // waiting for valid
    DEC_BUSY = 2'd1,  // access in flight
    DEC_DONE = 2'd2   // skip the held valid
  } dec_state_e;

endpackage

`default_nettype wire

//--- hdl/map_pkg.sv
`default_nettype none

package map_pkg;
  import bus_pkg::*;

  // ----------------------------------------
  // region decode
  // ----------------------------------------
  localparam logic [3:0] SRAM_REGION = 4'h4;   // addr[31:28]
  localparam logic [7:0] LED_REGION  = 8'h82;  // addr[31:24]

  localparam addr_t SRAM_BASE = 32'h4000_0000;
  localparam addr_t LED_BASE  = 32'h8200_0000;
  localparam addr_t NONE_BASE = 32'h2000_0000;  // nothing lives here

  // ----------------------------------------
  // scratch SRAM
  // ----------------------------------------
  localparam int SRAM_WORDS   = 256;
  localparam int SRAM_INDEX_W = 8;  // addr[9:2], aliases over the region
  typedef logic [SRAM_INDEX_W-1:0] sram_index_t;

  // ----------------------------------------
  // LED register block
  // ----------------------------------------
  localparam int LED_OFS_W = 22;  // word offset, addr[23:2]
  typedef logic [LED_OFS_W-1:0] led_ofs_t;
  localparam led_ofs_t LED_CTRL_OFS = led_ofs_t'(0);  // led enables
  localparam led_ofs_t LED_STAT_OFS = led_ofs_t'(1);  // blink flag

  localparam int LED_COUNT_W = 24;
  typedef logic [LED_COUNT_W-1:0] led_count_t;

  localparam word_t UNMAPPED_RDATA = 32'h0000_0000;

endpackage

`default_nettype wire

//--- hdl/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic    clk,
  input  logic    sys_resetn,
  input  logic    i_mem_valid,
  input  addr_t   i_mem_addr,
  input  word_t   i_mem_wdata,
  input  strb_t   i_mem_wstrb,
  input  logic    i_resp_done,   // o_mem_ready of the return stage
  output logic    o_sram_sel,
  output logic    o_led_sel,
  output logic    o_none_ack,
  output target_e o_target,
  output addr_t   o_addr,
  output word_t   o_wdata,
  output strb_t   o_wstrb
);

  dec_state_e state, state_nxt;
  target_e    dec_target;   // region of the incoming address
  logic       accept;       // valid taken this cycle
  logic       none_pend;    // empty region, ack follows next cycle

  // ----------------------------------------
  // address classification
  // ----------------------------------------
  always_comb begin
    if (i_mem_addr[31:28] == SRAM_REGION) begin
      dec_target = TGT_SRAM;
    end else if (i_mem_addr[31:24] == LED_REGION) begin
      dec_target = TGT_LED;
    end else begin
      dec_target = TGT_NONE;
    end
  end

  assign accept = (state == DEC_IDLE) && i_mem_valid;

  always_comb begin
    case (state)
      DEC_IDLE: state_nxt = i_mem_valid ? DEC_BUSY : DEC_IDLE;
      DEC_BUSY: state_nxt = i_resp_done ? DEC_DONE : DEC_BUSY;
      DEC_DONE: state_nxt = DEC_IDLE;  // master drops valid here
      default:  state_nxt = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      state      <= DEC_IDLE;
      o_sram_sel <= 1'b0;
      o_led_sel  <= 1'b0;
      none_pend  <= 1'b0;
      o_none_ack <= 1'b0;
      o_target   <= TGT_NONE;
    end else begin
      state      <= state_nxt;
      o_sram_sel <= accept && (dec_target == TGT_SRAM);  // one-cycle pulse
      o_led_sel  <= accept && (dec_target == TGT_LED);
      none_pend  <= accept && (dec_target == TGT_NONE);
      o_none_ack <= none_pend;  // lines up with a target ack
      if (accept) begin
        o_target <= dec_target;  // held until the next access
      end
    end
  end

  // access payload
  always_ff @(posedge clk) begin
    if (accept) begin
      o_addr  <= i_mem_addr;
      o_wdata <= i_mem_wdata;
      o_wstrb <= i_mem_wstrb;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic  clk,
  input  logic  sys_resetn,
  input  logic  i_sel,
  input  addr_t i_addr,
  input  word_t i_wdata,
  input  strb_t i_wstrb,
  output logic  o_ack,
  output word_t o_rdata
);

  word_t       mem [SRAM_WORDS];
  sram_index_t index;

  // upper address bits ignored, so the bank repeats every 1 KB
  assign index = i_addr[SRAM_INDEX_W+1:2];

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (i_sel) begin
      o_rdata <= mem[index];  // old word on a write
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (i_wstrb[lane]) begin
          mem[index][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // response
  // ----------------------------------------
  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= i_sel;  // one cycle after select
    end
  end

endmodule

`default_nettype wire

//--- hdl/led_regs.sv
`timescale 1ns/1ps
`default_nettype none

module led_regs
  import bus_pkg::*;
  import map_pkg::*;
#(
  parameter int BLINK_TICKS = 13_500_000  // clocks per blink half period
) (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic       i_sel,
  input  addr_t      i_addr,
  input  word_t      i_wdata,
  input  strb_t      i_wstrb,
  output logic       o_ack,
  output word_t      o_rdata,
  output logic [2:0] o_led
);

  localparam led_count_t BLINK_LAST = led_count_t'(BLINK_TICKS - 1);

  led_ofs_t   ofs;
  logic [1:0] ctrl;        // led enables, 1 = lit
  led_count_t blink_cnt;
  logic       blink;       // drives the pin directly
  word_t      rd_word;

  assign ofs = i_addr[LED_OFS_W+1:2];

  // ----------------------------------------
  // blink counter
  // ----------------------------------------
  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      blink_cnt <= '0;
      blink     <= 1'b1;  // led off
    end else if (blink_cnt == BLINK_LAST) begin
      blink_cnt <= '0;
      blink     <= ~blink;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // control register
  // ----------------------------------------
  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      ctrl <= 2'b00;
    end else if (i_sel && i_wstrb[0] && (ofs == LED_CTRL_OFS)) begin
      ctrl <= i_wdata[1:0];  // only byte lane 0 matters
    end
  end

  // pins are active low
  assign o_led = {blink, ~ctrl};

  // ----------------------------------------
  // readback
  // ----------------------------------------
  always_comb begin
    case (ofs)
      LED_CTRL_OFS: rd_word = word_t'(ctrl);
      LED_STAT_OFS: rd_word = word_t'(blink);
      default:      rd_word = '0;  // unused offsets
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_sel) begin
      o_rdata <= rd_word;  // value before any write
    end
  end

  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= i_sel;
    end
  end

endmodule

`default_nettype wire

//--- hdl/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic    clk,
  input  logic    sys_resetn,
  input  target_e i_target,
  input  logic    i_sram_ack,
  input  word_t   i_sram_rdata,
  input  logic    i_led_ack,
  input  word_t   i_led_rdata,
  input  logic    i_none_ack,
  output logic    o_mem_ready,
  output word_t   o_mem_rdata
);

  logic  sel_ack;
  word_t sel_rdata;

  // ----------------------------------------
  // pick the active target
  // ----------------------------------------
  always_comb begin
    case (i_target)
      TGT_SRAM: begin
        sel_ack   = i_sram_ack;
        sel_rdata = i_sram_rdata;
      end
      TGT_LED: begin
        sel_ack   = i_led_ack;
        sel_rdata = i_led_rdata;
      end
      default: begin
        sel_ack   = i_none_ack;
        sel_rdata = UNMAPPED_RDATA;  // empty region
      end
    endcase
  end

  // ----------------------------------------
  // registered response to the master
  // ----------------------------------------
  always_ff @(posedge clk or negedge sys_resetn) begin
    if (!sys_resetn) begin
      o_mem_ready <= 1'b0;
      o_mem_rdata <= '0;
    end else begin
      o_mem_ready <= sel_ack;  // single-cycle, acks are pulses
      if (sel_ack) begin
        o_mem_rdata <= sel_rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/pico_soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module pico_soc_fabric
  import bus_pkg::*;
#(
  parameter int BLINK_TICKS = 13_500_000  // 0.5 s at 27 MHz
) (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic       i_mem_valid,
  input  addr_t      i_mem_addr,
  input  word_t      i_mem_wdata,
  input  strb_t      i_mem_wstrb,
  output logic       o_mem_ready,
  output word_t      o_mem_rdata,
  output logic [2:0] o_led
);

  // decoded access
  addr_t   dec_addr;
  word_t   dec_wdata;
  strb_t   dec_wstrb;
  target_e target;

  logic  sram_sel;
  logic  sram_ack;
  word_t sram_rdata;

  logic  led_sel;
  logic  led_ack;
  word_t led_rdata;

  logic  none_ack;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  bus_decode u_bus_decode (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_mem_valid (i_mem_valid),
    .i_mem_addr  (i_mem_addr),
    .i_mem_wdata (i_mem_wdata),
    .i_mem_wstrb (i_mem_wstrb),
    .i_resp_done (o_mem_ready),  // frees the decoder
    .o_sram_sel  (sram_sel),
    .o_led_sel   (led_sel),
    .o_none_ack  (none_ack),
    .o_target    (target),
    .o_addr      (dec_addr),
    .o_wdata     (dec_wdata),
    .o_wstrb     (dec_wstrb)
  );

  // ----------------------------------------
  // targets
  // ----------------------------------------
  sram_bank u_sram_bank (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_sel      (sram_sel),
    .i_addr     (dec_addr),
    .i_wdata    (dec_wdata),
    .i_wstrb    (dec_wstrb),
    .o_ack      (sram_ack),
    .o_rdata    (sram_rdata)
  );

  led_regs #(
    .BLINK_TICKS (BLINK_TICKS)
  ) u_led_regs (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_sel      (led_sel),
    .i_addr     (dec_addr),
    .i_wdata    (dec_wdata),
    .i_wstrb    (dec_wstrb),
    .o_ack      (led_ack),
    .o_rdata    (led_rdata),
    .o_led      (o_led)
  );

  // ----------------------------------------
  // result
  // ----------------------------------------
  read_return u_read_return (
    .clk          (clk),
    .sys_resetn   (sys_resetn),
    .i_target     (target),
    .i_sram_ack   (sram_ack),
    .i_sram_rdata (sram_rdata),
    .i_led_ack    (led_ack),
    .i_led_rdata  (led_rdata),
    .i_none_ack   (none_ack),
    .o_mem_ready  (o_mem_ready),
    .o_mem_rdata  (o_mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------
// helpers
// ----------------------------------------
function automatic addr_t sram_addr(input int index);
  return SRAM_BASE + addr_t'(index * 4);  // word index to byte address
endfunction

task automatic report_mismatch(input string test, input string what,
                               input word_t expected, input word_t actual);
  $display("[ERROR] %s %s: expected %h, actual %h", test, what, expected, actual);
  error_count++;
endtask

task automatic close_test(input string test, input int errors_before);
  test_count++;
  if (error_count == errors_before) begin
    $display("%s: ok", test);
  end else begin
    fail_count++;
    $display("%s: %0d error(s)", test, error_count - errors_before);
  end
endtask

// ----------------------------------------
// bus master
// ----------------------------------------
// latency counts edges from the one that samples valid to the one that sees ready
task automatic run_access(input addr_t addr, input word_t wdata, input strb_t wstrb,
                          output word_t rdata, output int latency,
                          output logic ready_after);
  int   edges;
  logic seen;
  edges       = 0;
  seen        = 1'b0;
  rdata       = '0;
  ready_after = 1'b0;
  @(posedge clk);
  #DRIVE_DELAY;
  mem_valid = 1'b1;
  mem_addr  = addr;
  mem_wdata = wdata;
  mem_wstrb = wstrb;
  while (!seen && edges < BUS_TIMEOUT) begin
    @(posedge clk);
    #DRIVE_DELAY;
    edges++;
    if (mem_ready) begin
      seen  = 1'b1;
      rdata = mem_rdata;  // stable until the next edge
    end
  end
  latency = edges;
  if (!seen) begin
    $display("no ready within %0d cycles for the access at %h", BUS_TIMEOUT, addr);
    error_count++;
  end else begin
    @(posedge clk);  // handshake edge
    #DRIVE_DELAY;
    ready_after = mem_ready;
  end
  mem_valid = 1'b0;
  mem_wstrb = '0;
endtask

task automatic bus_write(input addr_t addr, input word_t wdata, input strb_t wstrb);
  word_t unused_rdata;
  int    unused_latency;
  logic  unused_ready;
  run_access(addr, wdata, wstrb, unused_rdata, unused_latency, unused_ready);
endtask

task automatic bus_read(input addr_t addr, output word_t rdata);
  int   unused_latency;
  logic unused_ready;
  run_access(addr, 32'h0, 4'h0, rdata, unused_latency, unused_ready);
endtask

task automatic wait_blink_toggle(input int limit, output int edges, output logic seen);
  logic start;
  start = led[2];
  edges = 0;
  seen  = 1'b0;
  while (!seen && edges < limit) begin
    @(posedge clk);
    #DRIVE_DELAY;
    edges++;
    if (led[2] !== start) begin
      seen = 1'b1;
    end
  end
  if (!seen) begin
    $display("blink_flag: led 2 did not toggle within %0d cycles", limit);
    error_count++;
  end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic sram_round_trip();
  word_t data [8];
  word_t got;
  int    errs;
  errs = error_count;
  for (int i = 0; i < 8; i++) begin
    data[i] = $urandom;
    bus_write(sram_addr(i * 31 + 3), data[i], 4'hf);
  end
  for (int i = 0; i < 8; i++) begin
    bus_read(sram_addr(i * 31 + 3), got);
    if (got !== data[i]) begin
      report_mismatch("sram_round_trip", "readback", data[i], got);
    end
    bus_read(sram_addr(i * 31 + 3) + 32'h400, got);  // 1 KB higher reads the same word
    if (got !== data[i]) begin
      report_mismatch("sram_round_trip", "alias", data[i], got);
    end
  end
  close_test("sram_round_trip", errs);
endtask

task automatic byte_lane_writes();
  word_t expect_word;
  word_t fill;
  word_t old;
  word_t got;
  int    lat;
  logic  ready_after;
  int    errs;
  errs        = error_count;
  expect_word = $urandom;
  bus_write(sram_addr(100), expect_word, 4'hf);
  for (int lane = 0; lane < 4; lane++) begin
    fill = expect_word ^ ($urandom | 32'h0101_0101);  // every byte differs
    run_access(sram_addr(100), fill, strb_t'(1 << lane), old, lat, ready_after);
    if (old !== expect_word) begin
      report_mismatch("byte_lane_writes", "word before write", expect_word, old);
    end
    expect_word[lane*8 +: 8] = fill[lane*8 +: 8];
    bus_read(sram_addr(100), got);
    if (got !== expect_word) begin
      report_mismatch("byte_lane_writes", "readback", expect_word, got);
    end
  end
  close_test("byte_lane_writes", errs);
endtask

task automatic led_control();
  word_t      val;
  word_t      got;
  logic [1:0] exp_led;
  int         errs;
  errs = error_count;
  for (int v = 0; v < 4; v++) begin
    val     = word_t'(v);
    exp_led = ~val[1:0];  // pins are active low
    bus_write(LED_CTRL_ADDR, val, 4'h1);
    if (led[1:0] !== exp_led) begin
      report_mismatch("led_control", "o_led[1:0]", word_t'(exp_led), word_t'(led[1:0]));
    end
    bus_read(LED_CTRL_ADDR, got);
    if (got !== val) begin
      report_mismatch("led_control", "ctrl readback", val, got);
    end
  end
  close_test("led_control", errs);
endtask

task automatic unmapped_region();
  word_t pattern;
  word_t got;
  int    errs;
  errs    = error_count;
  pattern = $urandom | 32'h1;
  bus_write(sram_addr(7), pattern, 4'hf);
  bus_write(LED_CTRL_ADDR, 32'h2, 4'h1);
  bus_read(sram_addr(7), got);  // nonzero data left on the bus
  bus_read(NONE_BASE, got);
  if (got !== 32'h0) begin
    report_mismatch("unmapped_region", "read data", 32'h0, got);
  end
  bus_write(NONE_BASE + 32'h1c, ~pattern, 4'hf);  // same low bits as sram word 7
  bus_write(NONE_BASE, 32'h1, 4'hf);              // same low bits as led ctrl
  bus_read(sram_addr(7), got);
  if (got !== pattern) begin
    report_mismatch("unmapped_region", "sram word", pattern, got);
  end
  bus_read(LED_CTRL_ADDR, got);
  if (got !== 32'h2) begin
    report_mismatch("unmapped_region", "led ctrl", 32'h2, got);
  end
  close_test("unmapped_region", errs);
endtask

task automatic blink_flag();
  int    edges;
  logic  seen;
  logic  level;
  word_t got;
  int    errs;
  errs = error_count;
  wait_blink_toggle(3 * BLINK_TICKS, edges, seen);
  if (seen) begin
    wait_blink_toggle(3 * BLINK_TICKS, edges, seen);  // one full half period
    if (seen && edges != BLINK_TICKS) begin
      report_mismatch("blink_flag", "toggle period", word_t'(BLINK_TICKS), word_t'(edges));
    end
  end
  level = led[2];  // bus idle here
  bus_read(LED_STAT_ADDR, got);
  if (got !== word_t'(level)) begin
    report_mismatch("blink_flag", "status readback", word_t'(level), got);
  end
  close_test("blink_flag", errs);
endtask

task automatic measure_latency(input string target, input addr_t addr);
  word_t got;
  int    lat;
  logic  ready_after;
  run_access(addr, 32'h0, 4'h0, got, lat, ready_after);
  if (lat != EXP_LATENCY) begin
    report_mismatch("response_latency", {target, " edges"}, word_t'(EXP_LATENCY),
                    word_t'(lat));
  end
  if (ready_after !== 1'b0) begin
    report_mismatch("response_latency", {target, " ready width"}, 32'h0,
                    word_t'(ready_after));
  end
endtask

task automatic response_latency();
  int errs;
  errs = error_count;
  measure_latency("sram", sram_addr(5));
  measure_latency("led", LED_CTRL_ADDR);
  measure_latency("unmapped", NONE_BASE);
  close_test("response_latency", errs);
endtask

`endif

//--- testbench/tb_pico_soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pico_soc_fabric
  import bus_pkg::*;
  import map_pkg::*;
();

  localparam int          BLINK_TICKS  = 20;  // short blink for simulation
  localparam int          CLK_HALF     = 2;   // 4 ns period
  localparam int          RESET_CYCLES = 16;
  localparam int          DRIVE_DELAY  = 1;   // after the rising edge
  localparam int          BUS_TIMEOUT  = 16;  // edges per access
  localparam int          EXP_LATENCY  = 3;
  localparam logic [31:0] RAND_SEED    = 32'h076d_25c4;

  localparam addr_t LED_CTRL_ADDR = LED_BASE + 32'h0;  // word offset 0
  localparam addr_t LED_STAT_ADDR = LED_BASE + 32'h4;  // word offset 1

  logic       clk;
  logic       sys_resetn;
  logic       mem_valid;
  addr_t      mem_addr;
  word_t      mem_wdata;
  strb_t      mem_wstrb;
  logic       mem_ready;
  word_t      mem_rdata;
  logic [2:0] led;

  int test_count;
  int fail_count;
  int error_count;

  pico_soc_fabric #(
    .BLINK_TICKS (BLINK_TICKS)
  ) i_pico_soc_fabric (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_mem_valid (mem_valid),
    .i_mem_addr  (mem_addr),
    .i_mem_wdata (mem_wdata),
    .i_mem_wstrb (mem_wstrb),
    .o_mem_ready (mem_ready),
    .o_mem_rdata (mem_rdata),
    .o_led       (led)
  );

  always #CLK_HALF clk = ~clk;

  `include "tb_tasks.svh"

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    clk         = 1'b0;
    sys_resetn  = 1'b0;
    mem_valid   = 1'b0;
    mem_addr    = '0;
    mem_wdata   = '0;
    mem_wstrb   = '0;
    test_count  = 0;
    fail_count  = 0;
    error_count = 0;
    void'($urandom(RAND_SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    sys_resetn = 1'b1;

    sram_round_trip();
    byte_lane_writes();
    led_control();
    unmapped_region();
    blink_flag();
    response_latency();

    $display("tests: %0d, failed: %0d, errors: %0d", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+testbench
hdl/bus_pkg.sv
hdl/map_pkg.sv
hdl/bus_decode.sv
hdl/sram_bank.sv
hdl/led_regs.sv
hdl/read_return.sv
hdl/pico_soc_fabric.sv
testbench/tb_pico_soc_fabric.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= tb_pico_soc_fabric
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tb_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
